// File: fdc_pkg.sv
package fdc_pkg;

  // sector geometry
  localparam int SECTOR_BYTES = 512;
  localparam int SECTOR_AW = 9;
  // N code for 512-byte sectors
  localparam logic [7:0] SECTOR_SIZE_CODE = 8'h02;

  // buffer depths
  localparam int RESULT_DEPTH = 7;
  localparam int PARAM_DEPTH = 8;

  // single result byte for bad commands and empty sense
  localparam logic [7:0] MSR_NO_CMD = 8'h80;

  // command codes, low five bits of the command byte
  localparam logic [4:0] CMD_READ_DATA = 5'h06;
  localparam logic [4:0] CMD_WRITE_DATA = 5'h05;
  localparam logic [4:0] CMD_SPECIFY = 5'h03;
  localparam logic [4:0] CMD_SENSE_DRIVE = 5'h04;
  localparam logic [4:0] CMD_RECALIBRATE = 5'h07;
  localparam logic [4:0] CMD_SENSE_INT = 5'h08;
  localparam logic [4:0] CMD_SEEK = 5'h0f;

  // interrupt code, st0 bits 7..6
  localparam logic [1:0] IC_OK = 2'b00;
  localparam logic [1:0] IC_ABNORMAL = 2'b01;

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_CMD,
    PH_EXEC,
    PH_RESULT
  } fdc_phase_e;

  typedef enum logic [2:0] {
    XS_IDLE,
    XS_START_READ,
    XS_READ_WAIT,
    XS_READING,
    XS_WRITE_FILL,
    XS_COMMIT
  } xfer_state_e;

  // one-cycle bus pulses plus the written byte
  typedef struct packed {
    logic       msr_rd;
    logic       data_rd;
    logic       data_wr;
    logic [7:0] wdata;
  } bus_event_t;

  // request word to the image host
  typedef struct packed {
    logic [8:0] rsvd_hi;    // 31..23
    logic       next_id;    // 22
    logic       rsvd_w1;    // 21, second drive write
    logic       write_req;  // 20
    logic [1:0] rsvd_r1;    // 19..18
    logic       read_req;   // 17
    logic       ack_ack;    // 16
    logic       head;
    logic [6:0] cylinder;
    logic [7:0] sector;
  } disk_req_t;

  // response word from the image host
  typedef struct packed {
    logic [25:0] rsvd_hi;
    logic        ready;
    logic        done;
    logic        not_found;
    logic [2:0]  rsvd_lo;
  } disk_resp_t;

  typedef struct packed {
    logic       start_read;
    logic       start_write;
    logic       head;
    logic [6:0] cylinder;
    logic [7:0] sector;
  } xfer_cmd_t;

  typedef struct packed {
    logic finished;
    logic not_found;
  } xfer_result_t;

endpackage

// File: fdc_sector_fifo.sv
`timescale 1ns/10ps

module fdc_sector_fifo #(
  parameter int DEPTH = fdc_pkg::SECTOR_BYTES
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       flush,
  input  logic       push,
  input  logic [7:0] d,
  input  logic       pop,
  output logic [7:0] q,
  output logic       empty,
  output logic       full
);

  localparam int AW = $clog2(DEPTH);

  logic [7:0] mem [DEPTH];
  // pointers wrap naturally, depth is a power of two
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0] count;

  assign empty = (count == '0);
  assign full = (count == DEPTH[AW:0]);
  // head of queue shown without a pop
  assign q = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= d;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop keep the count
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // producers must watch full and empty
  assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
  assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

// File: fdc_host_port.sv
`timescale 1ns/10ps

module fdc_host_port (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ce,
  input  logic                a0,
  input  logic                rd_n,
  input  logic                wr_n,
  input  logic [7:0]          din,
  input  logic [7:0]          rd_byte,
  output fdc_pkg::bus_event_t ev,
  output logic [7:0]          dout
);

  logic rd_n_q;
  logic wr_n_q;
  logic rd_fall;
  logic wr_fall;

  // falling strobe edges, only while selected
  assign rd_fall = rd_n_q && !rd_n && ce;
  assign wr_fall = wr_n_q && !wr_n && ce;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_n_q <= 1'b1;
      wr_n_q <= 1'b1;
      ev <= '0;
      dout <= 8'h00;
    end else begin
      rd_n_q <= rd_n;
      wr_n_q <= wr_n;
      // a0 low is the status register, read only
      ev.msr_rd <= rd_fall && !a0;
      ev.data_rd <= rd_fall && a0;
      ev.data_wr <= wr_fall && a0;
      ev.wdata <= din;
      // sequencer answers in the event cycle
      if (ev.msr_rd || ev.data_rd) begin
        dout <= rd_byte;
      end
    end
  end

  // CPU never drops both strobes at once
  assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({ev.msr_rd, ev.data_rd, ev.data_wr}));

endmodule

// File: fdc_sequencer.sv
`timescale 1ns/10ps

module fdc_sequencer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  fdc_pkg::bus_event_t   ev,
  input  logic [1:0]            disk_wp,
  input  logic                  drive_ready,
  input  logic [7:0]            fifo_rd_q,
  input  logic                  rd_empty,
  input  logic                  wr_full,
  input  fdc_pkg::xfer_result_t xres,
  output logic [7:0]            rd_byte,
  output logic                  pop_rd,
  output logic                  push_wr,
  output logic [7:0]            wr_byte,
  output fdc_pkg::xfer_cmd_t    xcmd
);
  import fdc_pkg::*;

  fdc_phase_e phase;
  logic [4:0] ins;
  logic [PARAM_DEPTH-1:0][7:0] params;
  logic [3:0] param_len;
  logic [2:0] param_pos;
  logic [RESULT_DEPTH-1:0][7:0] results;
  logic [2:0] res_len;
  logic [2:0] res_pos;
  // present cylinder and seek bookkeeping
  logic [6:0] pcn;
  logic seek_pend;
  logic head_q;
  logic [7:0] sect_q;
  // sector bytes moved by the CPU, bit SECTOR_AW means all done
  logic [SECTOR_AW:0] xfer_cnt;
  logic start_rd_q;
  logic start_wr_q;
  logic [7:0] p0;
  logic last_param;
  logic rd_exec;
  logic wr_exec;
  logic wr_open;
  logic rfm;
  logic dio;
  logic exm;
  logic busy;
  logic [7:0] msr;

  // st0, st1, st2, C, H, R, N for read and write
  function automatic logic [RESULT_DEPTH-1:0][7:0] sector_res(
    input logic [1:0] ic,
    input logic       nf,
    input logic       wp,
    input logic [2:0] unit,
    input logic [7:0] c,
    input logic       h,
    input logic [7:0] r
  );
    logic [RESULT_DEPTH-1:0][7:0] res;
    res[0] = {ic, 1'b1, 1'b0, !drive_ready, unit};
    // no data, write protect, missing mark
    res[1] = {5'b00000, nf, wp, nf};
    res[2] = {7'b0000000, nf};
    res[3] = c;
    res[4] = {7'b0000000, h};
    res[5] = r;
    res[6] = SECTOR_SIZE_CODE;
    return res;
  endfunction

  assign rd_exec = (phase == PH_EXEC) && (ins == CMD_READ_DATA);
  assign wr_exec = (phase == PH_EXEC) && (ins == CMD_WRITE_DATA);
  assign wr_open = wr_exec && !wr_full && !xfer_cnt[SECTOR_AW];

  // status register
  assign rfm = (phase != PH_EXEC) || (rd_exec && !rd_empty) || wr_open;
  assign dio = (phase == PH_RESULT) || rd_exec;
  assign exm = (phase == PH_EXEC);
  assign busy = (phase != PH_IDLE);
  assign msr = {rfm, dio, exm, busy, 4'b0000};

  assign pop_rd = ev.data_rd && rd_exec && !rd_empty;
  assign push_wr = ev.data_wr && wr_open;
  assign wr_byte = ev.wdata;

  // sense drive unit and head byte, still on the bus
  assign p0 = ev.wdata;
  assign last_param = ({1'b0, param_pos} + 4'd1) == param_len;

  assign xcmd = '{start_read: start_rd_q, start_write: start_wr_q,
                  head: head_q, cylinder: pcn, sector: sect_q};

  always_comb begin
    rd_byte = 8'hff;
    if (ev.msr_rd) begin
      rd_byte = msr;
    end else if (ev.data_rd && phase == PH_RESULT) begin
      rd_byte = results[res_pos];
    end else if (pop_rd) begin
      rd_byte = fifo_rd_q;
    end
  end

  always_ff @(posedge clk) begin
    start_rd_q <= 1'b0;
    start_wr_q <= 1'b0;
    if (!rst_n) begin
      phase <= PH_IDLE;
      param_len <= '0;
      param_pos <= '0;
      res_len <= '0;
      res_pos <= '0;
      pcn <= '0;
      seek_pend <= 1'b0;
      xfer_cnt <= '0;
    end else if (xres.finished && phase == PH_EXEC) begin
      // write done or sector missing
      phase <= PH_RESULT;
      res_pos <= '0;
      res_len <= 3'd7;
      results <= sector_res(xres.not_found ? IC_ABNORMAL : IC_OK, xres.not_found, 1'b0,
                            params[0][2:0], {1'b0, pcn}, head_q, sect_q);
    end else if (ev.data_wr) begin
      case (phase)
        PH_IDLE: begin
          ins <= ev.wdata[4:0];
          param_pos <= '0;
          res_pos <= '0;
          phase <= PH_CMD;
          case (ev.wdata[4:0])
            CMD_READ_DATA, CMD_WRITE_DATA: param_len <= 4'd8;
            CMD_SEEK, CMD_SPECIFY: param_len <= 4'd2;
            CMD_RECALIBRATE, CMD_SENSE_DRIVE: param_len <= 4'd1;
            CMD_SENSE_INT: begin
              phase <= PH_RESULT;
              seek_pend <= 1'b0;
              if (seek_pend) begin
                res_len <= 3'd2;
                results[0] <= {IC_OK, 1'b1, 1'b0, !drive_ready, params[0][2:0]};
                results[1] <= {1'b0, pcn};
              end else begin
                res_len <= 3'd1;
                results[0] <= MSR_NO_CMD;
              end
            end
            default: begin
              phase <= PH_RESULT;
              res_len <= 3'd1;
              results[0] <= MSR_NO_CMD;
            end
          endcase
        end
        PH_CMD: begin
          params[param_pos] <= ev.wdata;
          param_pos <= param_pos + 3'd1;
          if (last_param) begin
            xfer_cnt <= '0;
            res_pos <= '0;
            case (ins)
              CMD_SEEK: begin
                pcn <= ev.wdata[6:0];
                seek_pend <= 1'b1;
                phase <= PH_IDLE;
              end
              CMD_RECALIBRATE: begin
                pcn <= '0;
                seek_pend <= 1'b1;
                phase <= PH_IDLE;
              end
              CMD_SENSE_DRIVE: begin
                // st3 fault, wp, ready, track 0, two side, head, unit
                phase <= PH_RESULT;
                res_len <= 3'd1;
                results[0] <= {1'b0, disk_wp[p0[0]], drive_ready, pcn == 7'd0, 1'b0, p0[2:0]};
              end
              CMD_READ_DATA: begin
                pcn <= params[1][6:0];
                head_q <= params[2][0];
                sect_q <= params[3];
                start_rd_q <= 1'b1;
                phase <= PH_EXEC;
              end
              CMD_WRITE_DATA: begin
                if (disk_wp[params[0][0]]) begin
                  // refused, no disk request
                  phase <= PH_RESULT;
                  res_len <= 3'd7;
                  results <= sector_res(IC_ABNORMAL, 1'b0, 1'b1, params[0][2:0],
                                        params[1], params[2][0], params[3]);
                end else begin
                  pcn <= params[1][6:0];
                  head_q <= params[2][0];
                  sect_q <= params[3];
                  start_wr_q <= 1'b1;
                  phase <= PH_EXEC;
                end
              end
              // specify, timing bytes ignored
              default: phase <= PH_IDLE;
            endcase
          end
        end
        PH_EXEC: begin
          if (push_wr) begin
            xfer_cnt <= xfer_cnt + 1'b1;
          end
        end
        default: ;
      endcase
    end else if (ev.data_rd) begin
      if (phase == PH_RESULT) begin
        if (res_pos + 3'd1 == res_len) begin
          phase <= PH_IDLE;
          res_pos <= '0;
        end else begin
          res_pos <= res_pos + 3'd1;
        end
      end else if (pop_rd) begin
        xfer_cnt <= xfer_cnt + 1'b1;
        // last byte of the sector
        if (&xfer_cnt[SECTOR_AW-1:0]) begin
          phase <= PH_RESULT;
          res_pos <= '0;
          res_len <= 3'd7;
          results <= sector_res(IC_OK, 1'b0, 1'b0, params[0][2:0], {1'b0, pcn},
                                head_q, sect_q);
        end
      end
    end
  end

endmodule

// File: fdc_sector_xfer.sv
`timescale 1ns/10ps

module fdc_sector_xfer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  fdc_pkg::xfer_cmd_t    xcmd,
  input  logic                  push_wr,
  input  fdc_pkg::disk_resp_t   disk_resp,
  output fdc_pkg::xfer_result_t xres,
  output fdc_pkg::disk_req_t    disk_req,
  output logic                  flush
);
  import fdc_pkg::*;

  xfer_state_e state;
  // bytes pushed by the CPU in write mode
  logic [SECTOR_AW-1:0] wr_cnt;

  always_ff @(posedge clk) begin
    flush <= 1'b0;
    xres.finished <= 1'b0;
    if (!rst_n) begin
      state <= XS_IDLE;
      disk_req <= '0;
      xres.not_found <= 1'b0;
      wr_cnt <= '0;
    end else begin
      case (state)
        // a finished read waits here while the CPU drains the FIFO
        XS_IDLE, XS_READING: begin
          if (xcmd.start_read) begin
            flush <= 1'b1;
            // new request, flip the id
            disk_req.next_id <= !disk_req.next_id;
            disk_req.read_req <= 1'b1;
            disk_req.ack_ack <= 1'b0;
            disk_req.head <= xcmd.head;
            disk_req.cylinder <= xcmd.cylinder;
            disk_req.sector <= xcmd.sector;
            state <= XS_START_READ;
          end else if (xcmd.start_write) begin
            flush <= 1'b1;
            wr_cnt <= '0;
            state <= XS_WRITE_FILL;
          end
        end
        XS_START_READ: begin
          // let a stale done from the last request drop
          if (!disk_resp.done) begin
            state <= XS_READ_WAIT;
          end
        end
        XS_READ_WAIT: begin
          if (disk_resp.done) begin
            disk_req.read_req <= 1'b0;
            disk_req.ack_ack <= 1'b1;
            if (disk_resp.not_found) begin
              xres.finished <= 1'b1;
              xres.not_found <= 1'b1;
              state <= XS_IDLE;
            end else begin
              state <= XS_READING;
            end
          end
        end
        XS_WRITE_FILL: begin
          if (push_wr) begin
            wr_cnt <= wr_cnt + 1'b1;
            // 512th byte, hand the sector to the host
            if (&wr_cnt) begin
              disk_req.next_id <= !disk_req.next_id;
              disk_req.write_req <= 1'b1;
              disk_req.ack_ack <= 1'b0;
              disk_req.head <= xcmd.head;
              disk_req.cylinder <= xcmd.cylinder;
              disk_req.sector <= xcmd.sector;
              state <= XS_COMMIT;
            end
          end
        end
        XS_COMMIT: begin
          if (disk_resp.done) begin
            disk_req.write_req <= 1'b0;
            disk_req.ack_ack <= 1'b1;
            xres.finished <= 1'b1;
            xres.not_found <= disk_resp.not_found;
            state <= XS_IDLE;
          end
        end
        default: state <= XS_IDLE;
      endcase
    end
  end

  // one request at a time, each held until the host is done
  assert property (@(posedge clk) disable iff (!rst_n)
    !(disk_req.read_req && disk_req.write_req));
  assert property (@(posedge clk) disable iff (!rst_n)
    disk_req.write_req && !disk_resp.done |=> disk_req.write_req);

endmodule

// File: fdc_top.sv
`timescale 1ns/10ps

module fdc_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ce,
  input  logic                a0,
  input  logic                rd_n,
  input  logic                wr_n,
  input  logic [7:0]          din,
  output logic [7:0]          dout,
  input  logic [7:0]          disk_data_in,
  input  logic                disk_data_clkin,
  output logic [7:0]          disk_data_out,
  input  logic                disk_data_clkout,
  output fdc_pkg::disk_req_t  disk_sr,
  input  fdc_pkg::disk_resp_t disk_cr,
  input  logic [1:0]          disk_wp
);
  import fdc_pkg::*;

  bus_event_t ev;
  xfer_cmd_t xcmd;
  xfer_result_t xres;
  logic [7:0] rd_byte;
  logic [7:0] wr_byte;
  logic [7:0] fifo_rd_q;
  logic pop_rd;
  logic push_wr;
  logic rd_empty;
  logic wr_full;
  logic flush;

  fdc_host_port host_port_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .ce      (ce),
    .a0      (a0),
    .rd_n    (rd_n),
    .wr_n    (wr_n),
    .din     (din),
    .rd_byte (rd_byte),
    .ev      (ev),
    .dout    (dout)
  );

  fdc_sequencer sequencer_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .ev          (ev),
    .disk_wp     (disk_wp),
    .drive_ready (disk_cr.ready),
    .fifo_rd_q   (fifo_rd_q),
    .rd_empty    (rd_empty),
    .wr_full     (wr_full),
    .xres        (xres),
    .rd_byte     (rd_byte),
    .pop_rd      (pop_rd),
    .push_wr     (push_wr),
    .wr_byte     (wr_byte),
    .xcmd        (xcmd)
  );

  fdc_sector_xfer sector_xfer_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .xcmd      (xcmd),
    .push_wr   (push_wr),
    .disk_resp (disk_cr),
    .xres      (xres),
    .disk_req  (disk_sr),
    .flush     (flush)
  );

  // disk to CPU
  fdc_sector_fifo read_fifo_i (
    .clk   (clk),
    .rst_n (rst_n),
    .flush (flush),
    .push  (disk_data_clkin),
    .d     (disk_data_in),
    .pop   (pop_rd),
    .q     (fifo_rd_q),
    .empty (rd_empty),
    .full  ()
  );

  // CPU to disk
  fdc_sector_fifo write_fifo_i (
    .clk   (clk),
    .rst_n (rst_n),
    .flush (flush),
    .push  (push_wr),
    .d     (wr_byte),
    .pop   (disk_data_clkout),
    .q     (disk_data_out),
    .empty (),
    .full  (wr_full)
  );

endmodule

// File: tb_fdc_top.sv
`timescale 1ns/10ps

module tb_fdc_top;
  import fdc_pkg::*;

  localparam int MSR_TRIES = 50;
  localparam int REQ_TIMEOUT = 200;

  logic clk;
  logic rst_n;
  logic ce;
  logic a0;
  logic rd_n;
  logic wr_n;
  logic [7:0] din;
  logic [7:0] dout;
  logic [7:0] disk_data_in;
  logic disk_data_clkin;
  logic [7:0] disk_data_out;
  logic disk_data_clkout;
  disk_req_t disk_sr;
  disk_resp_t disk_cr;
  logic [1:0] disk_wp;

  // sector image shared by the CPU side and the disk model
  logic [7:0] sector_buf [SECTOR_BYTES];
  logic [15:0] lfsr_state;
  // next_id expected on the coming request
  logic req_id;

  fdc_top fdc_top_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .ce               (ce),
    .a0               (a0),
    .rd_n             (rd_n),
    .wr_n             (wr_n),
    .din              (din),
    .dout             (dout),
    .disk_data_in     (disk_data_in),
    .disk_data_clkin  (disk_data_clkin),
    .disk_data_out    (disk_data_out),
    .disk_data_clkout (disk_data_clkout),
    .disk_sr          (disk_sr),
    .disk_cr          (disk_cr),
    .disk_wp          (disk_wp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task check_equal(input string name, input logic [31:0] got, input logic [31:0] expected);
    if (got !== expected) begin
      $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, expected);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task timeout_fail(input string what);
    $display("timeout while waiting for %s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1, right shifting form
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hb400;
    end
    return s >> 1;
  endfunction

  // one lfsr step per data bit, msb first
  task fill_sector;
    logic [7:0] b;
    int i;
    int k;
    for (i = 0; i < SECTOR_BYTES; i = i + 1) begin
      b = 8'h00;
      for (k = 0; k < 8; k = k + 1) begin
        b = {b[6:0], lfsr_state[0]};
        lfsr_state = lfsr_step(lfsr_state);
      end
      sector_buf[i] = b;
    end
  endtask

  // st0 from the status rules, drive always ready here
  function automatic logic [7:0] expect_st0(input logic [1:0] ic, input logic [2:0] unit);
    return {ic, 6'b000000} | 8'h20 | {5'b00000, unit};
  endfunction

  function automatic logic [7:0] expect_st3(input logic wp, input logic rdy, input logic t0,
                                            input logic [2:0] unit);
    return {1'b0, wp, rdy, t0, 1'b0, unit};
  endfunction

  // strobe low for 4 cycles, dout valid 2 cycles after the edge
  task cpu_write(input logic addr, input logic [7:0] data);
    @(posedge clk);
    ce <= 1'b1;
    a0 <= addr;
    din <= data;
    wr_n <= 1'b0;
    repeat (4) @(posedge clk);
    wr_n <= 1'b1;
    ce <= 1'b0;
  endtask

  task cpu_read(input logic addr, output logic [7:0] data);
    @(posedge clk);
    ce <= 1'b1;
    a0 <= addr;
    rd_n <= 1'b0;
    repeat (4) @(posedge clk);
    data = dout;
    rd_n <= 1'b1;
    ce <= 1'b0;
  endtask

  // poll the status register
  task wait_msr(input logic [7:0] expected, input string what);
    logic [7:0] m;
    int tries;
    tries = 0;
    cpu_read(1'b0, m);
    while (m !== expected) begin
      tries = tries + 1;
      if (tries > MSR_TRIES) begin
        timeout_fail(what);
      end
      cpu_read(1'b0, m);
    end
  endtask

  // command, unit/head, C, H, R, N, EOT, GPL, DTL
  task send_rw_cmd(input logic [7:0] cmd, input logic [7:0] p0, input logic [7:0] c,
                   input logic [7:0] h, input logic [7:0] r);
    cpu_write(1'b1, cmd);
    cpu_write(1'b1, p0);
    cpu_write(1'b1, c);
    cpu_write(1'b1, h);
    cpu_write(1'b1, r);
    cpu_write(1'b1, 8'h02);
    cpu_write(1'b1, r);
    cpu_write(1'b1, 8'h1b);
    cpu_write(1'b1, 8'hff);
  endtask

  // seven result bytes of read and write
  task check_results(input logic [7:0] st0, input logic [7:0] st1, input logic [7:0] st2,
                     input logic [7:0] c, input logic [7:0] h, input logic [7:0] r);
    logic [7:0] expected [7];
    logic [7:0] b;
    int i;
    expected[0] = st0;
    expected[1] = st1;
    expected[2] = st2;
    expected[3] = c;
    expected[4] = h;
    expected[5] = r;
    expected[6] = 8'h02;
    wait_msr(8'hd0, "result phase");
    for (i = 0; i < 7; i = i + 1) begin
      cpu_read(1'b1, b);
      check_equal($sformatf("dout (result %0d)", i), b, expected[i]);
    end
    wait_msr(8'h80, "idle after results");
  endtask

  // disk model, read side
  task serve_read(input logic [6:0] c, input logic h, input logic [7:0] r, input logic nf);
    int t;
    int i;
    t = 0;
    @(posedge clk);
    while (!disk_sr.read_req) begin
      t = t + 1;
      if (t > REQ_TIMEOUT) begin
        timeout_fail("read request");
      end
      @(posedge clk);
    end
    // each request flips next_id, ack_ack drops with it
    req_id = !req_id;
    check_equal("disk_sr.next_id", disk_sr.next_id, req_id);
    check_equal("disk_sr.ack_ack", disk_sr.ack_ack, 1'b0);
    check_equal("disk_sr.write_req", disk_sr.write_req, 1'b0);
    check_equal("disk_sr.cylinder", disk_sr.cylinder, c);
    check_equal("disk_sr.head", disk_sr.head, h);
    check_equal("disk_sr.sector", disk_sr.sector, r);
    // image host latency
    repeat (3) @(posedge clk);
    if (!nf) begin
      for (i = 0; i < SECTOR_BYTES; i = i + 1) begin
        disk_data_clkin <= 1'b1;
        disk_data_in <= sector_buf[i];
        @(posedge clk);
      end
      disk_data_clkin <= 1'b0;
    end
    disk_cr.done <= 1'b1;
    disk_cr.not_found <= nf;
    t = 0;
    @(posedge clk);
    while (disk_sr.read_req) begin
      t = t + 1;
      if (t > REQ_TIMEOUT) begin
        timeout_fail("read request release");
      end
      @(posedge clk);
    end
    disk_cr.done <= 1'b0;
    disk_cr.not_found <= 1'b0;
  endtask

  // disk model, write side, pops and compares
  task serve_write(input logic [6:0] c, input logic h, input logic [7:0] r);
    int t;
    int i;
    t = 0;
    @(posedge clk);
    while (!disk_sr.write_req) begin
      t = t + 1;
      if (t > REQ_TIMEOUT) begin
        timeout_fail("write request");
      end
      @(posedge clk);
    end
    req_id = !req_id;
    check_equal("disk_sr.next_id", disk_sr.next_id, req_id);
    check_equal("disk_sr.ack_ack", disk_sr.ack_ack, 1'b0);
    check_equal("disk_sr.read_req", disk_sr.read_req, 1'b0);
    check_equal("disk_sr.cylinder", disk_sr.cylinder, c);
    check_equal("disk_sr.head", disk_sr.head, h);
    check_equal("disk_sr.sector", disk_sr.sector, r);
    for (i = 0; i < SECTOR_BYTES; i = i + 1) begin
      check_equal("disk_data_out", disk_data_out, sector_buf[i]);
      disk_data_clkout <= 1'b1;
      @(posedge clk);
      disk_data_clkout <= 1'b0;
      @(posedge clk);
    end
    disk_cr.done <= 1'b1;
    t = 0;
    @(posedge clk);
    while (disk_sr.write_req) begin
      t = t + 1;
      if (t > REQ_TIMEOUT) begin
        timeout_fail("write request release");
      end
      @(posedge clk);
    end
    disk_cr.done <= 1'b0;
  endtask

  task test_reset;
    logic [7:0] b;
    check_equal("dout", dout, 8'h00);
    check_equal("disk_sr", disk_sr, 32'h0);
    cpu_read(1'b0, b);
    check_equal("dout (msr)", b, 8'h80);
  endtask

  task test_invalid_cmd;
    logic [7:0] b;
    cpu_write(1'b1, 8'h1f);
    wait_msr(8'hd0, "invalid command result");
    cpu_read(1'b1, b);
    check_equal("dout (st0)", b, 8'h80);
    cpu_read(1'b0, b);
    check_equal("dout (msr)", b, 8'h80);
    // sense interrupt with no seek behind it
    cpu_write(1'b1, 8'h08);
    wait_msr(8'hd0, "sense interrupt result");
    cpu_read(1'b1, b);
    check_equal("dout (st0)", b, 8'h80);
    // specify, two timing bytes, no result phase
    cpu_write(1'b1, 8'h03);
    cpu_write(1'b1, 8'hdf);
    cpu_write(1'b1, 8'h02);
    cpu_read(1'b0, b);
    check_equal("dout (msr)", b, 8'h80);
  endtask

  task test_seek_sense;
    logic [7:0] b;
    @(posedge clk);
    disk_wp <= 2'b10;
    cpu_write(1'b1, 8'h0f);
    cpu_write(1'b1, 8'h01);
    cpu_write(1'b1, 8'd23);
    cpu_read(1'b0, b);
    check_equal("dout (msr)", b, 8'h80);
    cpu_write(1'b1, 8'h08);
    wait_msr(8'hd0, "seek sense result");
    cpu_read(1'b1, b);
    check_equal("dout (st0)", b, expect_st0(IC_OK, 3'd1));
    cpu_read(1'b1, b);
    check_equal("dout (pcn)", b, 8'd23);
    // off track 0, unit 0 not protected
    cpu_write(1'b1, 8'h04);
    cpu_write(1'b1, 8'h00);
    wait_msr(8'hd0, "sense drive result");
    cpu_read(1'b1, b);
    check_equal("dout (st3)", b, expect_st3(1'b0, 1'b1, 1'b0, 3'd0));
    cpu_write(1'b1, 8'h07);
    cpu_write(1'b1, 8'h01);
    cpu_write(1'b1, 8'h08);
    wait_msr(8'hd0, "recalibrate sense result");
    cpu_read(1'b1, b);
    check_equal("dout (st0)", b, expect_st0(IC_OK, 3'd1));
    cpu_read(1'b1, b);
    check_equal("dout (pcn)", b, 8'd0);
    // track 0, unit 1 protected, drive not ready
    @(posedge clk);
    disk_cr.ready <= 1'b0;
    cpu_write(1'b1, 8'h04);
    cpu_write(1'b1, 8'h01);
    wait_msr(8'hd0, "sense drive result");
    cpu_read(1'b1, b);
    check_equal("dout (st3)", b, expect_st3(1'b1, 1'b0, 1'b1, 3'd1));
    wait_msr(8'h80, "idle after sense drive");
    @(posedge clk);
    disk_wp <= 2'b00;
    disk_cr.ready <= 1'b1;
  endtask

  task test_read_data;
    logic [7:0] b;
    int i;
    fill_sector();
    send_rw_cmd(8'h46, 8'h04, 8'd5, 8'd1, 8'd3);
    // nothing buffered yet, rfm low and reads give 0xff
    cpu_read(1'b0, b);
    check_equal("dout (msr)", b, 8'h70);
    cpu_read(1'b1, b);
    check_equal("dout (empty fifo)", b, 8'hff);
    serve_read(7'd5, 1'b1, 8'd3, 1'b0);
    check_equal("disk_sr.ack_ack", disk_sr.ack_ack, 1'b1);
    wait_msr(8'hf0, "read data available");
    for (i = 0; i < SECTOR_BYTES; i = i + 1) begin
      cpu_read(1'b1, b);
      check_equal("dout (sector byte)", b, sector_buf[i]);
    end
    check_results(expect_st0(IC_OK, 3'd4), 8'h00, 8'h00, 8'd5, 8'd1, 8'd3);
  endtask

  task test_write_data;
    logic [7:0] b;
    int i;
    fill_sector();
    send_rw_cmd(8'h45, 8'h01, 8'd12, 8'd0, 8'd7);
    wait_msr(8'hb0, "write data request");
    check_equal("disk_sr.write_req", disk_sr.write_req, 1'b0);
    for (i = 0; i < SECTOR_BYTES; i = i + 1) begin
      cpu_write(1'b1, sector_buf[i]);
    end
    // full sector taken, rfm low
    cpu_read(1'b0, b);
    check_equal("dout (msr)", b, 8'h30);
    serve_write(7'd12, 1'b0, 8'd7);
    check_results(expect_st0(IC_OK, 3'd1), 8'h00, 8'h00, 8'd12, 8'd0, 8'd7);
  endtask

  task test_write_protect;
    @(posedge clk);
    disk_wp <= 2'b01;
    send_rw_cmd(8'h45, 8'h00, 8'd9, 8'd0, 8'd1);
    check_results(expect_st0(IC_ABNORMAL, 3'd0), 8'h02, 8'h00, 8'd9, 8'd0, 8'd1);
    check_equal("disk_sr.write_req", disk_sr.write_req, 1'b0);
    check_equal("disk_sr.read_req", disk_sr.read_req, 1'b0);
    @(posedge clk);
    disk_wp <= 2'b00;
  endtask

  task test_not_found;
    send_rw_cmd(8'h46, 8'h00, 8'd40, 8'd0, 8'd9);
    serve_read(7'd40, 1'b0, 8'd9, 1'b1);
    check_results(expect_st0(IC_ABNORMAL, 3'd0), 8'h05, 8'h01, 8'd40, 8'd0, 8'd9);
  endtask

  initial begin
    rst_n = 1'b0;
    ce = 1'b0;
    a0 = 1'b0;
    rd_n = 1'b1;
    wr_n = 1'b1;
    din = 8'h00;
    disk_data_in = 8'h00;
    disk_data_clkin = 1'b0;
    disk_data_clkout = 1'b0;
    disk_cr = '0;
    disk_cr.ready = 1'b1;
    disk_wp = 2'b00;
    lfsr_state = 16'd37145;
    req_id = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_invalid_cmd();
    test_seek_sense();
    test_read_data();
    test_write_data();
    test_write_protect();
    test_not_found();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: flist.f
fdc_pkg.sv
fdc_sector_fifo.sv
fdc_host_port.sv
fdc_sequencer.sv
fdc_sector_xfer.sv
fdc_top.sv
tb_fdc_top.sv

// File: Bender.yml
package:
  name: fdc

sources:
  - files:
      - fdc_pkg.sv
      - fdc_sector_fifo.sv
      - fdc_host_port.sv
      - fdc_sequencer.sv
      - fdc_sector_xfer.sv
      - fdc_top.sv
  - target: test
    files:
      - tb_fdc_top.sv
